// File: Bender.yml
package:
  name: memchk

sources:
  - memchk_pkg.sv
  - memchk_bus_if.sv
  - memchk_exp_if.sv
  - memchk_phase_fsm.sv
  - memchk_resp_counter.sv
  - memchk_req_compare.sv
  - memchk_top.sv
  - target: simulation
    files:
      - tb_memchk.sv

// File: memchk_bus_if.sv
// Observed data-bus request signals
// Pure observation bundle, the checker never drives the bus

`timescale 1ns/1ns

interface memchk_bus_if import memchk_pkg::*; ();

  logic              req;    // Request strobe
  logic              gnt;    // Grant strobe, meaningful with req
  logic              we;     // Write enable
  logic [ADDR_W-1:0] addr;   // Word address of the request
  logic [DATA_W-1:0] wdata;  // Store data, valid when we is set

  // Every consumer only watches
  modport monitor (
    input req,
    input gnt,
    input we,
    input addr,
    input wdata
  );

endinterface

// File: memchk_exp_if.sv
// Expected access for the current instruction
// Held stable by the environment from access start until done

`timescale 1ns/1ns

interface memchk_exp_if import memchk_pkg::*; ();

  logic              read;       // First request is a load
  logic              write;      // First request is a store
  logic              read_snd;   // Misaligned load needs a second request
  logic              write_snd;  // Misaligned store needs a second request
  logic [ADDR_W-1:0] fst_addr;
  logic [ADDR_W-1:0] snd_addr;
  logic [DATA_W-1:0] fst_wdata;
  logic [DATA_W-1:0] snd_wdata;
  logic [BE_W-1:0]   fst_be;     // Lanes that must match on the first store
  logic [BE_W-1:0]   snd_be;     // Lanes that must match on the second store

  modport sink (
    input read, write, read_snd, write_snd,
    input fst_addr, snd_addr,
    input fst_wdata, snd_wdata,
    input fst_be, snd_be
  );

endinterface

// File: memchk_phase_fsm.sv
// Tracks the grants of one access, first and optional second request
// A start pulse always wins over a grant in the same cycle
// Idles in PH_DONE after reset, so any request before the first start is extra

`timescale 1ns/1ns

module memchk_phase_fsm import memchk_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 access_start_i,  // One-cycle pulse per access
  memchk_bus_if.monitor        bus_if,
  memchk_exp_if.sink           exp_if,
  output phase_e               phase_o,
  output logic                 access_done_o,   // Pulse after the final grant
  output logic                 extra_req_o      // Pulse after a request in PH_DONE
);

  phase_e phase_q, phase_d;
  logic   grant;     // Request accepted this cycle
  logic   snd_exp;   // Split access expected
  logic   last_gnt;  // This grant completes the access

  assign grant   = bus_if.req & bus_if.gnt;
  assign snd_exp = exp_if.read_snd | exp_if.write_snd;

  // Final grant is the first one of an aligned access or the second of a split one
  assign last_gnt = grant & ~access_start_i &
                    (((phase_q == PH_FST) & ~snd_exp) | (phase_q == PH_SND));

  always_comb begin
    phase_d = phase_q;
    if (access_start_i) begin
      phase_d = PH_FST;                         // New access restarts tracking
    end else if (grant) begin
      case (phase_q)
        PH_FST:  phase_d = snd_exp ? PH_SND : PH_DONE;
        PH_SND:  phase_d = PH_DONE;
        default: phase_d = phase_q;             // Grants in PH_DONE are reported, not tracked
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phase_q       <= PH_DONE;
      access_done_o <= 1'b0;
      extra_req_o   <= 1'b0;
    end else begin
      phase_q       <= phase_d;
      access_done_o <= last_gnt;
      // Held requests keep flagging every cycle
      extra_req_o   <= bus_if.req & (phase_q == PH_DONE) & ~access_start_i;
    end
  end

  assign phase_o = phase_q;

endmodule

// File: memchk_pkg.sv
// Shared widths, limits and phase encoding for the data-memory checker
// Bus is one 32-bit word wide with one byte enable per byte
// Outstanding limit matches a core that issues at most two requests ahead

package memchk_pkg;

  // Data bus geometry
  localparam int unsigned ADDR_W = 32;  // Word address width
  localparam int unsigned DATA_W = 32;  // Write data width
  localparam int unsigned BE_W   = 4;   // One enable per byte lane

  // Lane width derived from the data word
  localparam int unsigned BYTE_W = DATA_W / BE_W;

  // Response bookkeeping
  localparam int unsigned MAX_OUTSTANDING = 2;  // Granted but unanswered requests
  localparam int unsigned CNT_W           = 2;  // Enough to hold MAX_OUTSTANDING

  // Progress of the current access
  // PH_DONE doubles as the idle state between accesses
  typedef enum logic [1:0] {
    PH_FST  = 2'd0,  // Waiting for the first grant
    PH_SND  = 2'd1,  // Waiting for the second grant of a split access
    PH_DONE = 2'd2   // All expected grants seen
  } phase_e;

endpackage

// File: memchk_req_compare.sv
// Compares every request cycle with the expectation of the current phase
// Only byte lanes with a set enable take part in the write data check
// Requests in PH_DONE are left to the phase FSM

`timescale 1ns/1ns

module memchk_req_compare import memchk_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  memchk_bus_if.monitor bus_if,
  memchk_exp_if.sink    exp_if,
  input  phase_e        phase_i,
  output logic          req_mismatch_o  // Pulse after a nonconforming request
);

  // Expectation selected for this phase
  logic              exp_rd, exp_wr;
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] exp_wdata;
  logic [BE_W-1:0]   exp_be;
  logic [DATA_W-1:0] mask;

  logic dir_ok, addr_ok, data_ok;
  logic active;                     // Phase where requests are expected
  logic mismatch_d;

  always_comb begin
    if (phase_i == PH_SND) begin    // Second half of a split access
      exp_rd    = exp_if.read_snd;
      exp_wr    = exp_if.write_snd;
      exp_addr  = exp_if.snd_addr;
      exp_wdata = exp_if.snd_wdata;
      exp_be    = exp_if.snd_be;
    end else begin
      exp_rd    = exp_if.read;
      exp_wr    = exp_if.write;
      exp_addr  = exp_if.fst_addr;
      exp_wdata = exp_if.fst_wdata;
      exp_be    = exp_if.fst_be;
    end
  end

  // Spread each byte enable over its lane
  always_comb begin
    for (int i = 0; i < BE_W; i++) begin
      mask[i*BYTE_W +: BYTE_W] = {BYTE_W{exp_be[i]}};
    end
  end

  // Read flag must be the exact complement of we, so neither or both set fails
  assign dir_ok  = (exp_wr == bus_if.we) && (exp_rd == ~bus_if.we);
  assign addr_ok = (bus_if.addr == exp_addr);
  assign data_ok = !bus_if.we || ((bus_if.wdata & mask) == (exp_wdata & mask));

  assign active     = (phase_i == PH_FST) || (phase_i == PH_SND);
  assign mismatch_d = bus_if.req & active & ~(dir_ok & addr_ok & data_ok);

  // Registered so a held request reports once per cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_mismatch_o <= 1'b0;
    end else begin
      req_mismatch_o <= mismatch_d;
    end
  end

endmodule

// File: memchk_resp_counter.sv
// Counts granted requests still waiting for their response
// Saturates at MAX_OUTSTANDING and at zero, errors are flagged instead of wrapping
// gnt_i must already be qualified with req

`timescale 1ns/1ns

module memchk_resp_counter import memchk_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             gnt_i,          // Accepted request
  input  logic             rvalid_i,       // Response beat
  output logic [CNT_W-1:0] outstanding_o,
  output logic             resp_err_o      // Pulse after a protocol violation
);

  logic [CNT_W-1:0] cnt_q;
  logic             inc, dec;
  logic             at_max, at_zero;
  logic             err_d;

  // Grant and response together cancel out
  assign inc = gnt_i & ~rvalid_i;
  assign dec = rvalid_i & ~gnt_i;

  assign at_max  = (cnt_q == CNT_W'(MAX_OUTSTANDING));
  assign at_zero = (cnt_q == '0);

  // Response with nothing pending, or one grant too many
  assign err_d = (rvalid_i & at_zero) | (inc & at_max);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q      <= '0;
      resp_err_o <= 1'b0;
    end else begin
      resp_err_o <= err_d;
      if (inc && !at_max) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (dec && !at_zero) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign outstanding_o = cnt_q;

endmodule

// File: memchk_top.sv
// Data-memory request conformance checker
// Expectation must stay stable from access_start_i until access_done_o
// Flags are one-cycle pulses, one cycle after the offending bus cycle

`timescale 1ns/1ns

module memchk_top import memchk_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              access_start_i,   // Begins a new access

  // Expected access
  input  logic              exp_read_i,
  input  logic              exp_write_i,
  input  logic              exp_read_snd_i,
  input  logic              exp_write_snd_i,
  input  logic [ADDR_W-1:0] exp_fst_addr_i,
  input  logic [ADDR_W-1:0] exp_snd_addr_i,
  input  logic [DATA_W-1:0] exp_fst_wdata_i,
  input  logic [DATA_W-1:0] exp_snd_wdata_i,
  input  logic [BE_W-1:0]   exp_fst_be_i,
  input  logic [BE_W-1:0]   exp_snd_be_i,

  // Observed data bus
  input  logic              data_req_i,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_we_i,
  input  logic [ADDR_W-1:0] data_addr_i,
  input  logic [DATA_W-1:0] data_wdata_i,

  // Verdicts
  output logic              req_mismatch_o,
  output logic              extra_req_o,
  output logic              resp_err_o,
  output logic              access_done_o,
  output logic [CNT_W-1:0]  outstanding_o
);

  memchk_bus_if bus_if ();
  memchk_exp_if exp_if ();
  phase_e       phase;

  assign bus_if.req   = data_req_i;
  assign bus_if.gnt   = data_gnt_i;
  assign bus_if.we    = data_we_i;
  assign bus_if.addr  = data_addr_i;
  assign bus_if.wdata = data_wdata_i;

  assign exp_if.read      = exp_read_i;
  assign exp_if.write     = exp_write_i;
  assign exp_if.read_snd  = exp_read_snd_i;
  assign exp_if.write_snd = exp_write_snd_i;
  assign exp_if.fst_addr  = exp_fst_addr_i;
  assign exp_if.snd_addr  = exp_snd_addr_i;
  assign exp_if.fst_wdata = exp_fst_wdata_i;
  assign exp_if.snd_wdata = exp_snd_wdata_i;
  assign exp_if.fst_be    = exp_fst_be_i;
  assign exp_if.snd_be    = exp_snd_be_i;

  memchk_phase_fsm u_phase_fsm (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .access_start_i (access_start_i),
    .bus_if         (bus_if),
    .exp_if         (exp_if),
    .phase_o        (phase),
    .access_done_o  (access_done_o),
    .extra_req_o    (extra_req_o)
  );

  // Counter sees only accepted requests
  memchk_resp_counter u_resp_counter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .gnt_i         (data_req_i & data_gnt_i),
    .rvalid_i      (data_rvalid_i),
    .outstanding_o (outstanding_o),
    .resp_err_o    (resp_err_o)
  );

  memchk_req_compare u_req_compare (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .bus_if         (bus_if),
    .exp_if         (exp_if),
    .phase_i        (phase),
    .req_mismatch_o (req_mismatch_o)
  );

endmodule

// File: sources.f
memchk_pkg.sv
memchk_bus_if.sv
memchk_exp_if.sv
memchk_phase_fsm.sv
memchk_resp_counter.sv
memchk_req_compare.sv
memchk_top.sv
tb_memchk.sv

// File: tb_memchk.sv
// Table-driven testbench for the data-memory checker
// Each row is driven on a rising edge and checked at the falling edge one cycle later
// Unenabled write-data lanes get random bytes, so they must never cause a mismatch

`timescale 1ns/1ns

module tb_memchk import memchk_pkg::*; ();

  localparam int MAX_ROWS = 40;
  localparam int CLK_HALF = 20;  // 40 ns period

  typedef struct packed {
    logic              start;
    logic              rd, wr, rd_snd, wr_snd;
    logic [ADDR_W-1:0] fa, sa;
    logic [DATA_W-1:0] fd, sd;
    logic [BE_W-1:0]   fbe, sbe;
    logic              req, gnt, rvalid, we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   keep;   // Lanes taken from the table while the rest get random bytes
    logic              mm, xr, re, dn;  // Expected flags one cycle later
    logic [CNT_W-1:0]  outst;
  } row_t;

  logic              clk_i, rst_i, access_start_i;
  logic              exp_read_i, exp_write_i, exp_read_snd_i, exp_write_snd_i;
  logic [ADDR_W-1:0] exp_fst_addr_i, exp_snd_addr_i;
  logic [DATA_W-1:0] exp_fst_wdata_i, exp_snd_wdata_i;
  logic [BE_W-1:0]   exp_fst_be_i, exp_snd_be_i;
  logic              data_req_i, data_gnt_i, data_rvalid_i, data_we_i;
  logic [ADDR_W-1:0] data_addr_i;
  logic [DATA_W-1:0] data_wdata_i;
  logic              req_mismatch_o, extra_req_o, resp_err_o, access_done_o;
  logic [CNT_W-1:0]  outstanding_o;

  row_t   tbl [0:MAX_ROWS-1];
  row_t   cur;                 // Expectation currently held by the environment
  int     n_rows      = 0;
  int     err_cnt     = 0;
  int     check_cnt   = 0;
  bit     table_ready = 1'b0;  // Set once the stimulus table is complete
  integer seed        = 32'hb407bd4f;

  memchk_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic set_expectation(input logic rd, wr, rd_snd, wr_snd,
                                 input logic [ADDR_W-1:0] fa, sa,
                                 input logic [DATA_W-1:0] fd, sd,
                                 input logic [BE_W-1:0] fbe, sbe);
    cur        = '0;
    cur.rd     = rd;
    cur.wr     = wr;
    cur.rd_snd = rd_snd;
    cur.wr_snd = wr_snd;
    cur.fa     = fa;
    cur.sa     = sa;
    cur.fd     = fd;
    cur.sd     = sd;
    cur.fbe    = fbe;
    cur.sbe    = sbe;
  endtask

  task automatic add_cycle(input logic start, req, gnt, rvalid, we,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input logic [BE_W-1:0] keep,
                           input logic mm, xr, re, dn, input logic [CNT_W-1:0] outst);
    row_t r;
    r        = cur;
    r.start  = start;
    r.req    = req;
    r.gnt    = gnt;
    r.rvalid = rvalid;
    r.we     = we;
    r.addr   = addr;
    r.wdata  = wdata;
    r.keep   = keep;
    r.mm     = mm;
    r.xr     = xr;
    r.re     = re;
    r.dn     = dn;
    r.outst  = outst;
    tbl[n_rows] = r;
    n_rows++;
  endtask

  task automatic build_table();
    // Aligned read granted then answered
    set_expectation(1, 0, 0, 0, 32'h1000, 32'h0, 32'h0, 32'h0, 4'h0, 4'h0);
    add_cycle(1, 0, 0, 0, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 1, 0, 0, 32'h1000, 32'h0, 4'h0, 0, 0, 0, 1, 2'd1);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
    add_cycle(0, 0, 0, 0, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
    // Split write with the top lane first and the low three lanes second
    set_expectation(0, 1, 0, 1, 32'h2000, 32'h2004, 32'hAABBCCDD, 32'h11223344,
                    4'b1000, 4'b0111);
    add_cycle(1, 0, 0, 0, 0, 32'h0,    32'h0,        4'h0,    0, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 1, 0, 1, 32'h2000, 32'hAABBCCDD, 4'b1000, 0, 0, 0, 0, 2'd1);
    add_cycle(0, 1, 1, 0, 1, 32'h2004, 32'h11223344, 4'b0111, 0, 0, 0, 1, 2'd2);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0,        4'h0,    0, 0, 0, 0, 2'd1);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0,        4'h0,    0, 0, 0, 0, 2'd0);
    // Same access again with a bad enabled byte and later a bad second address
    add_cycle(1, 0, 0, 0, 0, 32'h0,    32'h0,        4'h0,    0, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 0, 0, 1, 32'h2000, 32'h55BBCCDD, 4'b1000, 1, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 1, 0, 1, 32'h2000, 32'hAABBCCDD, 4'b1000, 0, 0, 0, 0, 2'd1);
    add_cycle(0, 1, 1, 0, 1, 32'h2008, 32'h11223344, 4'b0111, 1, 0, 0, 1, 2'd2);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0,        4'h0,    0, 0, 0, 0, 2'd1);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0,        4'h0,    0, 0, 0, 0, 2'd0);
    // Write held without grant while a read is expected flags every cycle
    set_expectation(1, 0, 0, 0, 32'h3000, 32'h0, 32'h0, 32'h0, 4'h0, 4'h0);
    add_cycle(1, 0, 0, 0, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 0, 0, 1, 32'h3000, 32'h0, 4'h0, 1, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 0, 0, 1, 32'h3000, 32'h0, 4'h0, 1, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 1, 0, 0, 32'h3000, 32'h0, 4'h0, 0, 0, 0, 1, 2'd1);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
    // Request after done without a new start
    add_cycle(0, 1, 0, 0, 0, 32'h3000, 32'h0, 4'h0, 0, 1, 0, 0, 2'd0);
    add_cycle(0, 0, 0, 0, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
    // Response with nothing outstanding
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0, 4'h0, 0, 0, 1, 0, 2'd0);
    // Split read followed by a third grant past the limit
    set_expectation(1, 0, 1, 0, 32'h4000, 32'h4004, 32'h0, 32'h0, 4'h0, 4'h0);
    add_cycle(1, 0, 0, 0, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
    add_cycle(0, 1, 1, 0, 0, 32'h4000, 32'h0, 4'h0, 0, 0, 0, 0, 2'd1);
    add_cycle(0, 1, 1, 0, 0, 32'h4004, 32'h0, 4'h0, 0, 0, 0, 1, 2'd2);
    add_cycle(0, 1, 1, 0, 0, 32'h4008, 32'h0, 4'h0, 0, 1, 1, 0, 2'd2);  // Count saturates
    add_cycle(0, 0, 0, 0, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd2);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd1);
    add_cycle(0, 0, 0, 1, 0, 32'h0,    32'h0, 4'h0, 0, 0, 0, 0, 2'd0);
  endtask

  task automatic drive_row(input row_t r);
    logic [DATA_W-1:0] rnd;
    logic [DATA_W-1:0] wd;
    rnd = $random(seed);
    wd  = r.wdata;
    for (int b = 0; b < BE_W; b++) begin
      if (!r.keep[b]) wd[b*BYTE_W +: BYTE_W] = rnd[b*BYTE_W +: BYTE_W];  // Don't-care lane
    end
    access_start_i  <= r.start;
    exp_read_i      <= r.rd;
    exp_write_i     <= r.wr;
    exp_read_snd_i  <= r.rd_snd;
    exp_write_snd_i <= r.wr_snd;
    exp_fst_addr_i  <= r.fa;
    exp_snd_addr_i  <= r.sa;
    exp_fst_wdata_i <= r.fd;
    exp_snd_wdata_i <= r.sd;
    exp_fst_be_i    <= r.fbe;
    exp_snd_be_i    <= r.sbe;
    data_req_i      <= r.req;
    data_gnt_i      <= r.gnt;
    data_rvalid_i   <= r.rvalid;
    data_we_i       <= r.we;
    data_addr_i     <= r.addr;
    data_wdata_i    <= wd;
  endtask

  task automatic check_flag(input int row, input string name,
                            input logic [CNT_W-1:0] got, exp);
    check_cnt++;
    if (got !== exp) begin
      $display("[ERROR] %0t ns: row %0d %s is %0d, expected %0d", $time, row, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_row(input int row, input row_t r);
    check_flag(row, "req_mismatch_o", CNT_W'(req_mismatch_o), CNT_W'(r.mm));
    check_flag(row, "extra_req_o",    CNT_W'(extra_req_o),    CNT_W'(r.xr));
    check_flag(row, "resp_err_o",     CNT_W'(resp_err_o),     CNT_W'(r.re));
    check_flag(row, "access_done_o",  CNT_W'(access_done_o),  CNT_W'(r.dn));
    check_flag(row, "outstanding_o",  outstanding_o,          r.outst);
  endtask

  // Watchdog sized from the table length plus reset and margin
  initial begin
    wait (table_ready);
    #((n_rows + 16 + 10) * 2 * CLK_HALF);
    $display("Run timed out before all table rows were checked");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst_i = 1'b1;
    cur   = '0;
    drive_row(cur);  // All inputs idle from time zero
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_row(-1, cur);  // Reset state has every flag low and a zero count
    for (int i = 0; i <= n_rows; i++) begin
      @(posedge clk_i);
      if (i < n_rows) drive_row(tbl[i]);
      @(negedge clk_i);
      if (i > 0) check_row(i - 1, tbl[i-1]);
    end
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
